//--- axi_lite_pkg.sv
// AXI4-Lite slave shared definitions.
// Fixed bus widths, memory depth, response codes and the
// packed channel structs used by the engines and the memory.

package axi_lite_pkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int MEM_WORDS  = 64;
    localparam int WORD_IDX_W = $clog2(MEM_WORDS);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;
    typedef logic [2:0]        prot_t;

    // AXI response codes.
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // --------------------
    // Channel payloads
    // --------------------

    // Address channel, shared by AR and AW.
    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_chan_t;

    // Write request from the write engine to the memory.
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } mem_wr_t;

endpackage

//--- axi_lite_slave_read.sv
// AXI4-Lite read engine.
// Opened by a start strobe from the memory, takes one AR beat,
// requests the word and returns it on R with OKAY or SLVERR.

module axi_lite_slave_read (
    input  logic                   clk,
    input  logic                   arstn,
    input  logic                   i_start_read,
    input  logic                   i_ar_valid,
    input  axi_lite_pkg::ar_chan_t i_ar,
    output logic                   o_ar_ready,
    input  logic                   i_r_ready,
    output axi_lite_pkg::r_chan_t  o_r,
    output logic                   o_r_valid,
    output logic                   o_rd_req,
    output axi_lite_pkg::addr_t    o_addr,
    input  axi_lite_pkg::data_t    i_data,
    input  logic                   i_successful_access,
    input  logic                   i_successful_read,
    output logic                   o_busy
);

    typedef enum logic [1:0] {
        IDLE,
        AR_WAIT,
        READ,
        RESP
    } state_t;

    state_t state;
    state_t next_state;
    logic   ar_fire;
    logic   r_fire;

    assign ar_fire = i_ar_valid & o_ar_ready;
    assign r_fire  = o_r_valid & i_r_ready;

    // Busy from the grant pulse until R is accepted.
    assign o_busy = (state != IDLE) | i_start_read;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (i_start_read) next_state = AR_WAIT;
            // No AR pending, so hand the port back.
            AR_WAIT: next_state = ar_fire ? READ : IDLE;
            READ:    if (i_successful_access) next_state = RESP;
            RESP:    if (r_fire) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state      <= IDLE;
            o_ar_ready <= 1'b0;
            o_rd_req   <= 1'b0;
            o_r_valid  <= 1'b0;
        end else begin
            state      <= next_state;
            o_ar_ready <= (state == IDLE) && i_start_read;
            o_rd_req   <= ar_fire;
            if ((state == READ) && i_successful_access) begin
                o_r_valid <= 1'b1;
            end else if (r_fire) begin
                o_r_valid <= 1'b0;
            end
        end
    end

    // Address and R payload.
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            o_addr <= i_ar.addr;
        end
        if ((state == READ) && i_successful_access) begin
            o_r.data <= i_data;
            o_r.resp <= i_successful_read ? axi_lite_pkg::RESP_OKAY
                                          : axi_lite_pkg::RESP_SLVERR;
        end
    end

endmodule

//--- axi_lite_slave_write.sv
// AXI4-Lite write engine.
// Takes one AW and one W beat in either order, issues a single
// memory write and answers on B with OKAY or SLVERR.

module axi_lite_slave_write (
    input  logic                   clk,
    input  logic                   arstn,
    input  logic                   i_start_write,
    input  logic                   i_aw_valid,
    input  axi_lite_pkg::ar_chan_t i_aw,
    output logic                   o_aw_ready,
    input  logic                   i_w_valid,
    input  axi_lite_pkg::w_chan_t  i_w,
    output logic                   o_w_ready,
    output logic                   o_b_valid,
    output axi_lite_pkg::resp_t    o_b_resp,
    input  logic                   i_b_ready,
    output logic                   o_wr_req,
    output axi_lite_pkg::mem_wr_t  o_wr,
    input  logic                   i_wr_done,
    input  logic                   i_wr_ok,
    output logic                   o_busy
);

    typedef enum logic [1:0] {
        IDLE,
        AW_W_WAIT,
        WRITE,
        RESP
    } state_t;

    state_t state;
    state_t next_state;
    logic   aw_fire;
    logic   w_fire;
    logic   aw_have;
    logic   w_have;
    logic   b_fire;

    assign aw_fire = i_aw_valid & o_aw_ready;
    assign w_fire  = i_w_valid & o_w_ready;
    assign b_fire  = o_b_valid & i_b_ready;

    // A channel is done once its ready has dropped or it fires now.
    assign aw_have = aw_fire | ~o_aw_ready;
    assign w_have  = w_fire | ~o_w_ready;

    assign o_busy = (state != IDLE) | i_start_write;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (i_start_write) next_state = AW_W_WAIT;
            AW_W_WAIT: begin
                if (aw_have && w_have) begin
                    next_state = WRITE;
                end else if (o_aw_ready && o_w_ready && !i_aw_valid && !i_w_valid) begin
                    // Nothing offered yet; release the port.
                    next_state = IDLE;
                end
            end
            WRITE:   if (i_wr_done) next_state = RESP;
            RESP:    if (b_fire) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state      <= IDLE;
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_wr_req   <= 1'b0;
            o_b_valid  <= 1'b0;
        end else begin
            state    <= next_state;
            o_wr_req <= (state == AW_W_WAIT) && (next_state == WRITE);
            if (state == IDLE) begin
                o_aw_ready <= i_start_write;
                o_w_ready  <= i_start_write;
            end else begin
                o_aw_ready <= o_aw_ready && !aw_fire && (next_state == AW_W_WAIT);
                o_w_ready  <= o_w_ready && !w_fire && (next_state == AW_W_WAIT);
            end
            if ((state == WRITE) && i_wr_done) begin
                o_b_valid <= 1'b1;
            end else if (b_fire) begin
                o_b_valid <= 1'b0;
            end
        end
    end

    // Write request and B payload.
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            o_wr.addr <= i_aw.addr;
        end
        if (w_fire) begin
            o_wr.data <= i_w.data;
            o_wr.strb <= i_w.strb;
        end
        if ((state == WRITE) && i_wr_done) begin
            o_b_resp <= i_wr_ok ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        end
    end

endmodule

//--- axi_lite_mem.sv
// Single-port word memory behind the AXI4-Lite engines.
// Checks alignment and range, merges byte strobes on writes,
// and grants the port to the read or write engine in turn.

module axi_lite_mem (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic                  i_rd_busy,
    input  logic                  i_wr_busy,
    output logic                  o_start_read,
    output logic                  o_start_write,
    input  logic                  i_rd_req,
    input  axi_lite_pkg::addr_t   i_rd_addr,
    output axi_lite_pkg::data_t   o_rd_data,
    output logic                  o_rd_valid,
    output logic                  o_rd_ok,
    input  logic                  i_wr_req,
    input  axi_lite_pkg::mem_wr_t i_wr,
    output logic                  o_wr_done,
    output logic                  o_wr_ok
);

    axi_lite_pkg::data_t                  mem [axi_lite_pkg::MEM_WORDS];
    logic [axi_lite_pkg::WORD_IDX_W-1:0]  rd_idx;
    logic [axi_lite_pkg::WORD_IDX_W-1:0]  wr_idx;
    logic                                 rd_good;
    logic                                 wr_good;
    logic                                 both_idle;
    logic                                 prio_wr;

    // Word index sits above the two byte-offset bits.
    assign rd_idx = i_rd_addr[axi_lite_pkg::WORD_IDX_W+1:2];
    assign wr_idx = i_wr.addr[axi_lite_pkg::WORD_IDX_W+1:2];

    // Good access: aligned, and no bits set above the memory range.
    assign rd_good = (i_rd_addr[1:0] == 2'b00) &&
                     (i_rd_addr[axi_lite_pkg::ADDR_W-1:axi_lite_pkg::WORD_IDX_W+2] == '0);
    assign wr_good = (i_wr.addr[1:0] == 2'b00) &&
                     (i_wr.addr[axi_lite_pkg::ADDR_W-1:axi_lite_pkg::WORD_IDX_W+2] == '0);

    // --------------------
    // Grant arbiter
    // --------------------
    assign both_idle = !i_rd_busy && !i_wr_busy;

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            o_start_read  <= 1'b0;
            o_start_write <= 1'b0;
            prio_wr       <= 1'b0;
        end else begin
            o_start_read  <= both_idle && !prio_wr;
            o_start_write <= both_idle && prio_wr;
            // Alternate after every grant.
            if (both_idle) begin
                prio_wr <= !prio_wr;
            end
        end
    end

    // --------------------
    // Storage and answers
    // --------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < axi_lite_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_req && wr_good) begin
            for (int b = 0; b < axi_lite_pkg::STRB_W; b++) begin
                if (i_wr.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_wr.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            o_rd_valid <= 1'b0;
            o_rd_ok    <= 1'b0;
            o_wr_done  <= 1'b0;
            o_wr_ok    <= 1'b0;
        end else begin
            o_rd_valid <= i_rd_req;
            o_rd_ok    <= i_rd_req && rd_good;
            o_wr_done  <= i_wr_req;
            o_wr_ok    <= i_wr_req && wr_good;
        end
    end

    // Bad reads return zero.
    always_ff @(posedge clk) begin
        if (i_rd_req) begin
            o_rd_data <= rd_good ? mem[rd_idx] : '0;
        end
    end

endmodule

//--- axi_lite_slave_top.sv
// AXI4-Lite slave top level.
// Connects the read engine, the write engine and the shared
// word memory with its grant arbiter.

module axi_lite_slave_top (
    input  logic                   clk,
    input  logic                   arstn,
    // Read address and data.
    input  logic                   i_ar_valid,
    input  axi_lite_pkg::ar_chan_t i_ar,
    output logic                   o_ar_ready,
    output logic                   o_r_valid,
    output axi_lite_pkg::r_chan_t  o_r,
    input  logic                   i_r_ready,
    // Write address, data and response.
    input  logic                   i_aw_valid,
    input  axi_lite_pkg::ar_chan_t i_aw,
    output logic                   o_aw_ready,
    input  logic                   i_w_valid,
    input  axi_lite_pkg::w_chan_t  i_w,
    output logic                   o_w_ready,
    output logic                   o_b_valid,
    output axi_lite_pkg::resp_t    o_b_resp,
    input  logic                   i_b_ready
);

    // --------------------
    // Internal wiring
    // --------------------
    logic                  rd_busy;
    logic                  wr_busy;
    logic                  start_read;
    logic                  start_write;
    logic                  rd_req;
    axi_lite_pkg::addr_t   rd_addr;
    axi_lite_pkg::data_t   rd_data;
    logic                  rd_valid;
    logic                  rd_ok;
    logic                  wr_req;
    axi_lite_pkg::mem_wr_t wr;
    logic                  wr_done;
    logic                  wr_ok;

    axi_lite_slave_read u_read (
        .clk                 (clk),
        .arstn               (arstn),
        .i_start_read        (start_read),
        .i_ar_valid          (i_ar_valid),
        .i_ar                (i_ar),
        .o_ar_ready          (o_ar_ready),
        .i_r_ready           (i_r_ready),
        .o_r                 (o_r),
        .o_r_valid           (o_r_valid),
        .o_rd_req            (rd_req),
        .o_addr              (rd_addr),
        .i_data              (rd_data),
        .i_successful_access (rd_valid),
        .i_successful_read   (rd_ok),
        .o_busy              (rd_busy)
    );

    axi_lite_slave_write u_write (
        .clk           (clk),
        .arstn         (arstn),
        .i_start_write (start_write),
        .i_aw_valid    (i_aw_valid),
        .i_aw          (i_aw),
        .o_aw_ready    (o_aw_ready),
        .i_w_valid     (i_w_valid),
        .i_w           (i_w),
        .o_w_ready     (o_w_ready),
        .o_b_valid     (o_b_valid),
        .o_b_resp      (o_b_resp),
        .i_b_ready     (i_b_ready),
        .o_wr_req      (wr_req),
        .o_wr          (wr),
        .i_wr_done     (wr_done),
        .i_wr_ok       (wr_ok),
        .o_busy        (wr_busy)
    );

    axi_lite_mem u_mem (
        .clk           (clk),
        .arstn         (arstn),
        .i_rd_busy     (rd_busy),
        .i_wr_busy     (wr_busy),
        .o_start_read  (start_read),
        .o_start_write (start_write),
        .i_rd_req      (rd_req),
        .i_rd_addr     (rd_addr),
        .o_rd_data     (rd_data),
        .o_rd_valid    (rd_valid),
        .o_rd_ok       (rd_ok),
        .i_wr_req      (wr_req),
        .i_wr          (wr),
        .o_wr_done     (wr_done),
        .o_wr_ok       (wr_ok)
    );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset source.
// 100 ns clock, reset held low for the first 10 cycles.

module tb_clock_gen (
    output logic clk,
    output logic arstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release away from the rising edge.
    initial begin
        arstn = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
    end
endmodule

//--- axi_lite_chk.sv
// AXI channel rule checker for the AXI4-Lite slave.
// Holds R and B stable under back-pressure, keeps the engines
// exclusive and checks the quiet state after reset.

module axi_lite_chk (
    input logic                  clk,
    input logic                  arstn,
    input logic                  i_r_valid,
    input axi_lite_pkg::r_chan_t i_r,
    input logic                  i_r_ready,
    input logic                  i_b_valid,
    input axi_lite_pkg::resp_t   i_b_resp,
    input logic                  i_b_ready,
    input logic                  i_ar_ready,
    input logic                  i_aw_ready,
    input logic                  i_w_ready,
    input logic                  i_rd_busy,
    input logic                  i_wr_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    r_hold: assert property (@(posedge clk) disable iff (!arstn)
        i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r))
        else $error("R dropped or changed before acceptance");

    b_hold: assert property (@(posedge clk) disable iff (!arstn)
        i_b_valid && !i_b_ready |=> i_b_valid && $stable(i_b_resp))
        else $error("B dropped or changed before acceptance");

    one_engine: assert property (@(posedge clk) disable iff (!arstn)
        !(i_rd_busy && i_wr_busy))
        else $error("Read and write engines busy together");

    // First edge out of reset.
    quiet_reset: assert property (@(posedge clk) $rose(arstn) |->
        !(i_ar_ready || i_aw_ready || i_w_ready || i_r_valid || i_b_valid))
        else $error("Handshake output high right after reset");
endmodule

bind axi_lite_slave_top axi_lite_chk u_chk (
    .clk        (clk),
    .arstn      (arstn),
    .i_r_valid  (o_r_valid),
    .i_r        (o_r),
    .i_r_ready  (i_r_ready),
    .i_b_valid  (o_b_valid),
    .i_b_resp   (o_b_resp),
    .i_b_ready  (i_b_ready),
    .i_ar_ready (o_ar_ready),
    .i_aw_ready (o_aw_ready),
    .i_w_ready  (o_w_ready),
    .i_rd_busy  (rd_busy),
    .i_wr_busy  (wr_busy)
);

//--- axi_lite_tb.sv
// Directed testbench for the AXI4-Lite slave.
// Drives AR/AW/W, applies R and B back-pressure and checks the
// responses against a word model of the memory.

module axi_lite_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;

    logic                   clk;
    logic                   arstn;
    logic                   ar_valid;
    axi_lite_pkg::ar_chan_t ar;
    logic                   ar_ready;
    logic                   r_valid;
    axi_lite_pkg::r_chan_t  r;
    logic                   r_ready;
    logic                   aw_valid;
    axi_lite_pkg::ar_chan_t aw;
    logic                   aw_ready;
    logic                   w_valid;
    axi_lite_pkg::w_chan_t  w;
    logic                   w_ready;
    logic                   b_valid;
    axi_lite_pkg::resp_t    b_resp;
    logic                   b_ready;

    axi_lite_pkg::data_t model [axi_lite_pkg::MEM_WORDS];
    int                  cycles;

    tb_clock_gen u_clk (.clk(clk), .arstn(arstn));

    axi_lite_slave_top DUT (
        .clk        (clk),
        .arstn      (arstn),
        .i_ar_valid (ar_valid),
        .i_ar       (ar),
        .o_ar_ready (ar_ready),
        .o_r_valid  (r_valid),
        .o_r        (r),
        .i_r_ready  (r_ready),
        .i_aw_valid (aw_valid),
        .i_aw       (aw),
        .o_aw_ready (aw_ready),
        .i_w_valid  (w_valid),
        .i_w        (w),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .o_b_resp   (b_resp),
        .i_b_ready  (b_ready)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input axi_lite_pkg::data_t exp,
                              input axi_lite_pkg::data_t act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_on_error("Data mismatch");
        end
    endtask

    task automatic check_resp(input string name, input axi_lite_pkg::resp_t exp,
                              input axi_lite_pkg::resp_t act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_on_error("Response mismatch");
        end
    endtask

    // Aligned and inside the memory.
    function automatic logic addr_good(input axi_lite_pkg::addr_t addr);
        return (addr[1:0] == 2'b00) && (int'(addr) < axi_lite_pkg::MEM_WORDS * 4);
    endfunction

    function automatic axi_lite_pkg::addr_t rand_good_addr();
        return axi_lite_pkg::addr_t'($urandom_range(0, axi_lite_pkg::MEM_WORDS - 1) * 4);
    endfunction

    // --------------------
    // Bus tasks
    // --------------------
    task automatic read_word(input axi_lite_pkg::addr_t addr);
        axi_lite_pkg::data_t   exp_data;
        axi_lite_pkg::resp_t   exp_resp;
        axi_lite_pkg::r_chan_t held;
        int unsigned           stall;
        exp_data = addr_good(addr) ? model[int'(addr) / 4] : '0;
        exp_resp = addr_good(addr) ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        stall = $urandom_range(0, 4);
        @(posedge clk);
        ar_valid <= 1'b1;
        ar.addr  <= addr;
        ar.prot  <= '0;
        do @(negedge clk); while (!ar_ready);
        @(posedge clk);
        ar_valid <= 1'b0;
        do @(negedge clk); while (!r_valid);
        held = r;
        // Master stalls; R must hold.
        repeat (stall) begin
            @(negedge clk);
            if (!r_valid) stop_on_error("R valid dropped before the master accepted it");
            check_data("o_r.data", held.data, r.data);
            check_resp("o_r.resp", held.resp, r.resp);
        end
        @(posedge clk);
        r_ready <= 1'b1;
        @(posedge clk);
        r_ready <= 1'b0;
        check_data("o_r.data", exp_data, held.data);
        check_resp("o_r.resp", exp_resp, held.resp);
    endtask

    task automatic write_word(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                              input axi_lite_pkg::strb_t strb, input logic w_lead);
        axi_lite_pkg::resp_t exp_resp;
        axi_lite_pkg::resp_t held;
        int unsigned         lead;
        int unsigned         stall;
        logic                aw_done;
        logic                w_done;
        logic                aw_go;
        logic                w_go;
        exp_resp = addr_good(addr) ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        lead = w_lead ? $urandom_range(1, 3) : 0;
        stall = $urandom_range(0, 4);
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge clk);
        w_valid <= 1'b1;
        w.data  <= data;
        w.strb  <= strb;
        aw.addr <= addr;
        aw.prot <= '0;
        if (!w_lead) aw_valid <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_go = aw_valid && aw_ready;
            w_go = w_valid && w_ready;
            @(posedge clk);
            if (aw_go) begin
                aw_valid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_go) begin
                w_valid <= 1'b0;
                w_done = 1'b1;
            end
            if (lead > 0) begin
                lead--;
                if (lead == 0) aw_valid <= 1'b1;
            end
        end
        do @(negedge clk); while (!b_valid);
        held = b_resp;
        repeat (stall) begin
            @(negedge clk);
            if (!b_valid) stop_on_error("B valid dropped before the master accepted it");
            check_resp("o_b_resp", held, b_resp);
        end
        @(posedge clk);
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
        check_resp("o_b_resp", exp_resp, held);
        // Byte merge into the model on a good write.
        if (addr_good(addr)) begin
            for (int b = 0; b < axi_lite_pkg::STRB_W; b++) begin
                if (strb[b]) model[int'(addr) / 4][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic reset_state_reads();
        repeat (4) read_word(rand_good_addr());
    endtask

    task automatic word_writes_readback(input logic partial);
        axi_lite_pkg::addr_t addrs [6];
        axi_lite_pkg::strb_t strb;
        foreach (addrs[i]) begin
            addrs[i] = rand_good_addr();
            strb = partial ? axi_lite_pkg::strb_t'($urandom_range(1, 15)) : 4'hf;
            write_word(addrs[i], axi_lite_pkg::data_t'($urandom()), strb, 1'b0);
        end
        foreach (addrs[i]) read_word(addrs[i]);
    endtask

    task automatic bad_address_access();
        axi_lite_pkg::addr_t base;
        axi_lite_pkg::addr_t off;
        axi_lite_pkg::data_t word;
        repeat (3) begin
            base = rand_good_addr();
            off = {axi_lite_pkg::addr_t'($urandom_range(1, 255)) << 8} | base;
            // Nonzero word behind the bad addresses, so a leak or a stray write shows up.
            word = axi_lite_pkg::data_t'($urandom() | 32'h0000_0001);
            write_word(base, word, 4'hf, 1'b0);
            write_word(base | axi_lite_pkg::addr_t'($urandom_range(1, 3)), ~word, 4'hf, 1'b0);
            write_word(off, ~word, 4'hf, 1'b0);
            read_word(base | 16'h0002);
            read_word(off);
            read_word(base);
        end
    endtask

    task automatic backpressure_and_order();
        axi_lite_pkg::addr_t ra;
        axi_lite_pkg::addr_t wa;
        repeat (4) begin
            wa = rand_good_addr();
            write_word(wa, axi_lite_pkg::data_t'($urandom()),
                       axi_lite_pkg::strb_t'($urandom_range(1, 15)), 1'b1);
            read_word(wa);
        end
        repeat (4) begin
            wa = rand_good_addr();
            ra = axi_lite_pkg::addr_t'((int'(wa) + 4) % (axi_lite_pkg::MEM_WORDS * 4));
            fork
                read_word(ra);
                write_word(wa, axi_lite_pkg::data_t'($urandom()), 4'hf, 1'b0);
            join
            read_word(wa);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) stop_on_error("Run timed out waiting for the DUT");
    end

    initial begin
        void'($urandom(32'hbc84));
        cycles = 0;
        ar_valid = 1'b0;
        ar = '0;
        r_ready = 1'b0;
        aw_valid = 1'b0;
        aw = '0;
        w_valid = 1'b0;
        w = '0;
        b_ready = 1'b0;
        foreach (model[i]) model[i] = '0;
        wait (arstn);
        @(posedge clk);
        reset_state_reads();
        word_writes_readback(1'b0);
        word_writes_readback(1'b1);
        bad_address_access();
        backpressure_and_order();
        repeat (2) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end
endmodule

//--- sources.f
axi_lite_pkg.sv
axi_lite_slave_read.sv
axi_lite_slave_write.sv
axi_lite_mem.sv
axi_lite_slave_top.sv
tb_clock_gen.sv
axi_lite_chk.sv
axi_lite_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI4-Lite slave testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module axi_lite_tb -f sources.f \
    -o axi_lite_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/axi_lite_sim > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
